//--- build.f
src/dlxPkg.sv
src/jumpBranch.sv
src/regFile.sv
src/pcUnit.sv
src/dlxBranchCore.sv
tests/dlxBranchCore_properties.sv
tests/dlxBranchCoreTb.sv

//--- src/dlxBranchCore.sv
`timescale 1ns/1ps
`default_nettype none

// Control-flow slice of a DLX core
// PC register, register file and jump/branch decoder
module dlxBranchCore import dlxPkg::*; #(
	parameter wordT RESET_PC = '0 // Word the PC takes at reset
) (
	input  wire logic    clk,
	input  wire logic    rstN,        // Sync, active low
	input  wire logic    instrValid,  // Strobe for instr
	input  wire wordT    instr,
	input  wire logic    regWrEn,     // Loader port
	input  wire regAddrT regWrAddr,
	input  wire wordT    regWrData,
	input  wire regAddrT dbgRdAddr,   // Debug read, combinational
	output wordT         pc,
	output logic         branchTaken,
	output wordT         dbgRdData
);

	// PC unit outputs
	wordT pcPlusFour;

	// Decoder outputs
	wordT nextPc;
	logic taken;
	logic linkWrEn;
	wordT linkData;

	// Operand path
	regAddrT rsAddr;
	wordT    rs1Value;

	assign rsAddr = instr[25:21]; // rs field

	pcUnit #(
		.RESET_PC(RESET_PC)
	) pcUnitInst (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.nextPc     (nextPc),
		.taken      (taken),
		.pc         (pc),
		.pcPlusFour (pcPlusFour),
		.branchTaken(branchTaken)
	);

	// Port A feeds the decoder, port B is the debug tap
	regFile regFileInst (
		.clk       (clk),
		.rstN      (rstN),
		.rdAddrA   (rsAddr),
		.rdDataA   (rs1Value),
		.rdAddrB   (dbgRdAddr),
		.rdDataB   (dbgRdData),
		.linkWrEn  (linkWrEn),
		.linkData  (linkData),
		.loadWrEn  (regWrEn),
		.loadWrAddr(regWrAddr),
		.loadWrData(regWrData),
		.instrValid(instrValid)
	);

	jumpBranch jumpBranchInst (
		.instr     (instr),
		.pcPlusFour(pcPlusFour),
		.rs1Value  (rs1Value),
		.nextPc    (nextPc),
		.taken     (taken),
		.linkWrEn  (linkWrEn),  // Gated by instrValid inside regFile
		.linkData  (linkData)
	);

endmodule

`default_nettype wire

//--- src/dlxPkg.sv
`default_nettype none

package dlxPkg;

	// Datapath word, also used for every address
	typedef logic [31:0] wordT;

	// Index into the register file
	typedef logic [4:0] regAddrT;

	// Primary opcode, instr[31:26]
	typedef logic [5:0] opcodeT;

	// Register file depth, r0 included
	localparam int NUM_REGS = 32;

	// Byte distance between two instructions
	localparam wordT PC_STEP = 32'd4;

	// Control-flow opcodes
	localparam opcodeT OP_J    = 6'h02; // PC+4 + sext(name)
	localparam opcodeT OP_JAL  = 6'h03; // Same as j, plus link
	localparam opcodeT OP_BEQZ = 6'h04; // Taken when rs1 == 0
	localparam opcodeT OP_BNEZ = 6'h05; // Taken when rs1 != 0
	localparam opcodeT OP_JR   = 6'h12; // PC = rs1

	// jal writes its return address here
	localparam regAddrT LINK_REG = 5'd31;

endpackage

`default_nettype wire

//--- src/jumpBranch.sv
`timescale 1ns/1ps
`default_nettype none

// Next-PC decoder for one instruction
// Purely combinational, instrValid is applied downstream
module jumpBranch import dlxPkg::*; (
	input  wire wordT instr,      // Instruction word under decode
	input  wire wordT pcPlusFour, // Address of the following instruction
	input  wire wordT rs1Value,   // Contents of register rs1
	output wordT      nextPc,     // Where the PC goes next
	output logic      taken,      // Control transfer happened
	output logic      linkWrEn,   // Request to write r31
	output wordT      linkData    // Return address for jal
);

	// Instruction fields
	opcodeT      opcode;
	logic [25:0] name;  // J-type offset
	logic [15:0] imm;   // I-type offset

	// Sign-extended offsets
	wordT nameExt;
	wordT immExt;

	// Candidate targets
	wordT jumpTarget;   // j, jal
	wordT branchTarget; // beqz, bnez

	logic rs1IsZero;

	assign opcode = instr[31:26];
	assign name   = instr[25:0];
	assign imm    = instr[15:0];

	// Replicate the top bit of each offset
	assign nameExt = {{6{name[25]}}, name};
	assign immExt  = {{16{imm[15]}}, imm};

	// Both targets are relative to PC+4
	assign jumpTarget   = pcPlusFour + nameExt;
	assign branchTarget = pcPlusFour + immExt;

	assign rs1IsZero = (rs1Value == '0);

	// Return address is always PC+4, only the enable depends on opcode
	assign linkData = pcPlusFour;

	always_comb begin
		// Fall-through unless a rule below fires
		nextPc   = pcPlusFour;
		taken    = 1'b0;
		linkWrEn = 1'b0;

		case (opcode)
			OP_J: begin
				nextPc = jumpTarget;
				taken  = 1'b1;
			end

			OP_JAL: begin
				nextPc   = jumpTarget;
				taken    = 1'b1;
				linkWrEn = 1'b1; // Save PC+4 in r31
			end

			OP_JR: begin
				nextPc = rs1Value; // Register-indirect, no offset
				taken  = 1'b1;
			end

			OP_BEQZ: begin
				if (rs1IsZero) begin
					nextPc = branchTarget;
					taken  = 1'b1;
				end
			end

			OP_BNEZ: begin
				if (!rs1IsZero) begin
					nextPc = branchTarget;
					taken  = 1'b1;
				end
			end

			default: begin
				// ALU, load/store and everything else just step on
				nextPc = pcPlusFour;
				taken  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter with PC+4 adder and registered branch pulse
module pcUnit import dlxPkg::*; #(
	parameter wordT RESET_PC = '0 // Must be word aligned
) (
	input  wire logic clk,
	input  wire logic rstN,
	input  wire logic instrValid,  // One instruction retires this edge
	input  wire wordT nextPc,      // From the jump/branch decoder
	input  wire logic taken,       // Decoder's taken flag, unqualified
	output wordT      pc,          // Current instruction address
	output wordT      pcPlusFour,  // Fall-through address
	output logic      branchTaken  // One-cycle pulse after a taken transfer
);

	// Fall-through is combinational off the PC register
	assign pcPlusFour = pc + PC_STEP;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc          <= RESET_PC;
			branchTaken <= 1'b0;
		end else begin
			if (instrValid) begin
				pc <= nextPc; // Hold otherwise
			end
			// Low whenever no instruction was accepted
			branchTaken <= instrValid && taken;
		end
	end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

// 32 x 32 register file, r0 hardwired to zero
// Two async read ports, one write port shared by jal link and loader
module regFile import dlxPkg::*; (
	input  wire logic    clk,
	input  wire logic    rstN,
	input  wire regAddrT rdAddrA,    // Port A, rs1 of the instruction
	output wordT         rdDataA,
	input  wire regAddrT rdAddrB,    // Port B, debug readback
	output wordT         rdDataB,
	input  wire logic    linkWrEn,   // jal link request from decoder
	input  wire wordT    linkData,   // Return address
	input  wire logic    loadWrEn,   // Loader write strobe
	input  wire regAddrT loadWrAddr,
	input  wire wordT    loadWrData,
	input  wire logic    instrValid  // Qualifies linkWrEn
);

	// r0 has no storage
	wordT regs [1:NUM_REGS-1];

	logic linkWrite;
	logic loadWrite;

	// Zero for r0, stored word otherwise
	function automatic wordT readReg(input regAddrT addr);
		if (addr == '0) begin
			return '0;
		end
		return regs[addr];
	endfunction

	// Link only counts on an accepted instruction
	assign linkWrite = linkWrEn && instrValid;

	// Loader writes to r0 are dropped here
	assign loadWrite = loadWrEn && (loadWrAddr != '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (linkWrite) begin
			regs[LINK_REG] <= linkData; // Link beats loader in the same cycle
		end else if (loadWrite) begin
			regs[loadWrAddr] <= loadWrData;
		end
	end

	// Async reads, no write bypass
	always_comb begin
		rdDataA = readReg(rdAddrA);
		rdDataB = readReg(rdAddrB);
	end

endmodule

`default_nettype wire

//--- tests/dlxBranchCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

// Table-driven testbench for the DLX control-flow slice
module dlxBranchCoreTb import dlxPkg::*; ();

	localparam wordT RESET_PC   = 32'h0000_0400; // Nonzero so the parameter path is seen
	localparam int   CLK_HALF   = 4;             // 8 ns period
	localparam int   RESET_LEN  = 16;
	localparam int   WAIT_LIMIT = 20;            // Cycles before any wait gives up
	localparam int   MAX_TESTS  = 16;
	localparam int   RAND_SEED  = 90;

	// DUT ports
	logic    clk;
	logic    rstN;
	logic    instrValid;
	wordT    instr;
	logic    regWrEn;
	regAddrT regWrAddr;
	wordT    regWrData;
	regAddrT dbgRdAddr;
	wordT    pc;
	logic    branchTaken;
	wordT    dbgRdData;

	// Edge counters that the wait loops poll
	int cycleCount  = 0;
	int retireCount = 0; // Edges with instrValid high
	int resetCycles = 0;

	// Reference register contents
	wordT regModel [NUM_REGS];

	// Stimulus columns
	int      numTests = 0;
	string   testName   [MAX_TESTS];
	opcodeT  testOp     [MAX_TESTS];
	regAddrT testRs     [MAX_TESTS];
	int      testOffset [MAX_TESTS]; // Intended signed byte offset
	wordT    testInstr  [MAX_TESTS];

	// Expected columns, filled by the model
	wordT expPc    [MAX_TESTS];
	logic expTaken [MAX_TESTS];
	wordT expLink  [MAX_TESTS]; // r31 after the entry

	dlxBranchCore #(
		.RESET_PC(RESET_PC)
	) UUT (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.regWrEn    (regWrEn),
		.regWrAddr  (regWrAddr),
		.regWrData  (regWrData),
		.dbgRdAddr  (dbgRdAddr),
		.pc         (pc),
		.branchTaken(branchTaken),
		.dbgRdData  (dbgRdData)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (!rstN) begin
			resetCycles <= resetCycles + 1;
		end
		if (rstN && instrValid) begin
			retireCount <= retireCount + 1; // One instruction accepted
		end
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			abortRun($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic checkAssertions(input string name);
		if (UUT.props.failCount != 0) begin
			abortRun($sformatf("A bound assertion fired by the end of %s", name));
		end
	endtask

	// Returns on the falling edge after the next rising edge
	task automatic waitCycle();
		int startCount;
		int guard;
		startCount = cycleCount;
		guard      = 0;
		while (cycleCount == startCount) begin
			@(negedge clk);
			guard++;
			if (guard > WAIT_LIMIT) begin
				abortRun("Timeout: the clock stopped advancing");
			end
		end
	endtask

	task automatic waitRetire(input string name);
		int startCount;
		int guard;
		startCount = retireCount;
		guard      = 0;
		while (retireCount == startCount) begin
			@(negedge clk);
			guard++;
			if (guard > WAIT_LIMIT) begin
				abortRun($sformatf("Timeout: instruction of %s was never accepted", name));
			end
		end
	endtask

	task automatic waitReset();
		int guard;
		guard = 0;
		while (resetCycles < RESET_LEN) begin
			@(negedge clk);
			guard++;
			if (guard > RESET_LEN + WAIT_LIMIT) begin
				abortRun("Timeout: reset cycles did not complete");
			end
		end
	endtask

	// Loader port, one write per cycle
	task automatic writeReg(input regAddrT addr, input wordT data);
		regWrEn   = 1'b1;
		regWrAddr = addr;
		regWrData = data;
		waitCycle();
		regWrEn = 1'b0;
	endtask

	task automatic readBack(input regAddrT addr, output wordT data);
		dbgRdAddr = addr;
		waitCycle(); // Settled well before the next falling edge
		data = dbgRdData;
	endtask

	// J-type keeps 26 offset bits, everything else is I-type with rt = r1
	function automatic wordT encode(input opcodeT op, input regAddrT rs, input int offset);
		wordT word;
		if (op == OP_J || op == OP_JAL) begin
			word = {op, offset[25:0]};
		end else begin
			word = {op, rs, 5'd1, offset[15:0]};
		end
		return word;
	endfunction

	task automatic addEntry(input string name, input opcodeT op, input regAddrT rs,
			input int offset);
		testName[numTests]   = name;
		testOp[numTests]     = op;
		testRs[numTests]     = rs;
		testOffset[numTests] = offset;
		testInstr[numTests]  = encode(op, rs, offset);
		numTests++;
	endtask

	task automatic buildTable();
		addEntry("plain_rtype", 6'h00, 5'd4, 0);
		addEntry("plain_addi", 6'h08, 5'd2, 16);
		addEntry("j_forward", OP_J, 5'd0, 64);
		addEntry("j_backward", OP_J, 5'd0, -36);
		addEntry("jal_forward", OP_JAL, 5'd0, 256);
		addEntry("plain_lw", 6'h23, 5'd1, 8);
		addEntry("jr_return", OP_JR, LINK_REG, 0);       // Back to the jal's PC+4
		addEntry("beqz_r0_taken", OP_BEQZ, 5'd0, 16);
		addEntry("beqz_r3_not", OP_BEQZ, 5'd3, 32);
		addEntry("bnez_r3_taken", OP_BNEZ, 5'd3, -8);
		addEntry("bnez_r0_not", OP_BNEZ, 5'd0, 48);
		addEntry("jal_backward", OP_JAL, 5'd0, -128);
		addEntry("beqz_r0_back", OP_BEQZ, 5'd0, -64);
		addEntry("bnez_r17_far", OP_BNEZ, 5'd17, 32764);  // Largest positive imm
		addEntry("j_far_back", OP_J, 5'd0, -1048576);
	endtask

	// Walk the table with the control-flow rules, starting from reset
	task automatic computeExpected();
		wordT modelPc;
		wordT seqPc;
		wordT target;
		wordT rsValue;
		modelPc = RESET_PC;
		for (int i = 0; i < numTests; i++) begin
			seqPc   = modelPc + 32'd4;
			target  = seqPc + wordT'(testOffset[i]); // Two's complement add
			rsValue = regModel[testRs[i]];           // r0 entry is always zero
			case (testOp[i])
				OP_J: begin
					modelPc     = target;
					expTaken[i] = 1'b1;
				end
				OP_JAL: begin
					modelPc              = target;
					expTaken[i]          = 1'b1;
					regModel[LINK_REG]   = seqPc; // Return address
				end
				OP_JR: begin
					modelPc     = rsValue;
					expTaken[i] = 1'b1;
				end
				OP_BEQZ: begin
					expTaken[i] = (rsValue == '0);
					modelPc     = expTaken[i] ? target : seqPc;
				end
				OP_BNEZ: begin
					expTaken[i] = (rsValue != '0);
					modelPc     = expTaken[i] ? target : seqPc;
				end
				default: begin
					modelPc     = seqPc;
					expTaken[i] = 1'b0;
				end
			endcase
			expPc[i]   = modelPc;
			expLink[i] = regModel[LINK_REG];
		end
	endtask

	// One accepted instruction followed by one idle cycle
	task automatic applyEntry(input int idx);
		string name;
		name       = testName[idx];
		instr      = testInstr[idx];
		instrValid = 1'b1;
		waitRetire(name);
		checkWord({name, "_pc"}, expPc[idx], pc);
		checkBit({name, "_taken"}, expTaken[idx], branchTaken);
		checkWord({name, "_r31"}, expLink[idx], dbgRdData);
		instrValid = 1'b0; // instr stays put, so a jal here must not link again
		waitCycle();
		checkWord({name, "_idle_pc"}, expPc[idx], pc);
		checkBit({name, "_idle_taken"}, 1'b0, branchTaken);
		checkWord({name, "_idle_r31"}, expLink[idx], dbgRdData);
	endtask

	initial begin
		wordT value;
		wordT readData;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		regWrEn    = 1'b0;
		regWrAddr  = '0;
		regWrData  = '0;
		dbgRdAddr  = '0;
		void'($urandom(RAND_SEED));
		for (int r = 0; r < NUM_REGS; r++) begin
			regModel[r] = '0;
		end

		waitReset();
		rstN = 1'b1;

		// Reset state of PC, pulse and every register
		checkWord("reset_pc", RESET_PC, pc);
		checkBit("reset_branchTaken", 1'b0, branchTaken);
		for (int r = 0; r < NUM_REGS; r++) begin
			readBack(regAddrT'(r), readData);
			checkWord($sformatf("reset_r%0d", r), '0, readData);
		end

		// Seed r1..r31 with random nonzero words
		for (int r = 1; r < NUM_REGS; r++) begin
			value = $urandom();
			while (value == '0) begin
				value = $urandom();
			end
			writeReg(regAddrT'(r), value);
			regModel[r] = value;
		end
		writeReg('0, $urandom() | 32'h1); // r0 keeps reading zero
		for (int r = 0; r < NUM_REGS; r++) begin
			readBack(regAddrT'(r), readData);
			checkWord($sformatf("seed_r%0d", r), regModel[r], readData);
		end
		checkWord("seed_pc_hold", RESET_PC, pc); // Loader leaves the PC alone
		checkAssertions("register seeding");

		buildTable();
		computeExpected();
		dbgRdAddr = LINK_REG; // Watch r31 through the table
		waitCycle();
		for (int i = 0; i < numTests; i++) begin
			applyEntry(i);
			checkAssertions(testName[i]);
		end

		if (UUT.props.failCount != 0) begin
			abortRun("Bound assertions fired during the run");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tests/dlxBranchCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Checks on reset state, r0 and PC behavior, bound into dlxBranchCore
module dlxBranchCoreProperties import dlxPkg::*; #(
	parameter wordT RESET_PC = '0 // Same vector as the bound core
) (
	input wire logic    clk,
	input wire logic    rstN,
	input wire logic    instrValid,
	input wire wordT    pc,
	input wire logic    branchTaken,
	input wire regAddrT dbgRdAddr,
	input wire wordT    dbgRdData
);

	// Number of fired assertions, polled by the testbench
	int failCount = 0;

	// Sync reset loads the vector and clears the pulse one edge later
	resetState: assert property (@(posedge clk) !rstN |=> (pc == RESET_PC) && !branchTaken)
		else begin
			failCount++;
			$error("pc or branchTaken wrong one cycle after reset");
		end

	// r0 has no storage, debug port must show zero
	regZeroReads: assert property (@(posedge clk) (dbgRdAddr == '0) |-> (dbgRdData == '0))
		else begin
			failCount++;
			$error("debug read of r0 returned a nonzero word");
		end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else begin
			failCount++;
			$error("pc is not word aligned");
		end

	// No accepted instruction, so PC holds and no pulse
	pcHold: assert property (@(posedge clk) disable iff (!rstN)
			!instrValid |=> $stable(pc) && !branchTaken)
		else begin
			failCount++;
			$error("pc moved or branchTaken rose after an idle edge");
		end

endmodule

bind dlxBranchCore dlxBranchCoreProperties #(
	.RESET_PC(RESET_PC)
) props (
	.clk        (clk),
	.rstN       (rstN),
	.instrValid (instrValid),
	.pc         (pc),
	.branchTaken(branchTaken),
	.dbgRdAddr  (dbgRdAddr),
	.dbgRdData  (dbgRdData)
);

`default_nettype wire
